/* filelist.f */
+incdir+source
source/msrh_lsu_pkg.sv
source/msrh_l2_req_port.sv
source/msrh_l2_arbiter.sv
source/msrh_l2_behavior_ram.sv
source/msrh_l2_subsys.sv
sim/tb_msrh_l2_subsys.sv

/* run.sh */
#!/bin/sh
# compile with verilator and run, a $fatal in the testbench gives a nonzero exit
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_msrh_l2_subsys -f filelist.f -o tb_msrh_l2_subsys &&
./obj_dir/tb_msrh_l2_subsys ||
{ echo "simulation did not pass"; exit 1; }

/* sim/tb_msrh_l2_subsys.sv */
`include "msrh_l2_params.svh"

module tb_msrh_l2_subsys;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int  WORDS    = `MSRH_L2_RAM_WORDS;
   localparam int  TAG_W    = `MSRH_L2_TAG_W;
   localparam int  BE_W     = `MSRH_L2_DATA_W / 8;
   localparam int  N_BURST  = 16;
   localparam int  N_MIX    = 40;
   localparam int  N_REQ    = WORDS + 3 * N_BURST + 4 * N_MIX;
   localparam time T_CLK    = 20ns;
   localparam time T_SAMPLE = 5ns;  // request ready sampled this long after the falling edge
   localparam time T_CHECK  = 7ns;  // response sampled after the request ready
   localparam time T_WD     = N_REQ * (`MSRH_L2_RD_LAT + 10) * T_CLK;
   localparam logic [15:0] SEED = 16'd44349;

   logic                   i_clk;
   logic                   i_msrh_reset_n;
   logic                   i_l1d_req_valid;
   msrh_lsu_pkg::l2_req_t  i_l1d_req;
   logic                   o_l1d_req_ready;
   logic                   o_l1d_resp_valid;
   msrh_lsu_pkg::l2_resp_t o_l1d_resp;
   logic                   i_l1d_resp_ready;
   logic                   i_ic_req_valid;
   msrh_lsu_pkg::l2_req_t  i_ic_req;
   logic                   o_ic_req_ready;
   logic                   o_ic_resp_valid;
   msrh_lsu_pkg::l2_resp_t o_ic_resp;
   logic                   i_ic_resp_ready;

   msrh_lsu_pkg::l2_data_t model_mem [WORDS];
   msrh_lsu_pkg::l2_resp_t exp_l1d [$];
   msrh_lsu_pkg::l2_resp_t exp_ic [$];
   msrh_lsu_pkg::paddr_t   wr_list [$];
   logic [15:0]            st_main;
   logic [15:0]            st_ic;
   logic [15:0]            st_l1d_stall;
   logic [15:0]            st_ic_stall;
   logic                   stall_en;

   msrh_l2_subsys u_msrh_l2_subsys (.*);

   initial begin
      i_clk = 1'b0;
      forever #(T_CLK / 2) i_clk = ~i_clk;
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
   endfunction

   task automatic rand_bits(inout logic [15:0] st, input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = st[0];
         st   = lfsr_step(st);
      end
   endtask

   function automatic int word_index(input msrh_lsu_pkg::paddr_t addr);
      msrh_lsu_pkg::paddr_t ofs;
      ofs = addr - `MSRH_L2_BASE_ADDR;
      return int'((ofs / BE_W) % WORDS);
   endfunction

   function automatic msrh_lsu_pkg::l2_data_t ref_read(input msrh_lsu_pkg::paddr_t addr);
      return model_mem[word_index(addr)];
   endfunction

   function automatic void model_write(input msrh_lsu_pkg::l2_req_t req);
      int idx;
      idx = word_index(req.addr);
      for (int b = 0; b < BE_W; b++) begin
         if (req.byte_en[b]) begin
            model_mem[idx][b*8 +: 8] = req.data[b*8 +: 8];
         end
      end
   endfunction

   // port overwrites the top tag bit with its source id
   function automatic msrh_lsu_pkg::l2_resp_t ref_resp(input msrh_lsu_pkg::l2_req_t req,
                                                       input logic src);
      msrh_lsu_pkg::l2_resp_t r;
      r.tag  = {src, req.tag[TAG_W-2:0]};
      r.data = ref_read(req.addr);
      return r;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_resp(input string name, input msrh_lsu_pkg::l2_resp_t act,
                             input msrh_lsu_pkg::l2_resp_t want);
      if (act !== want) begin
         fail_run($sformatf("MISMATCH time %0t %s actual %h expected %h",
                            $time, name, act, want));
      end
   endtask

   task automatic check_valid(input string name, input logic act, input logic want);
      if (act !== want) begin
         fail_run($sformatf("MISMATCH time %0t %s actual %b expected %b",
                            $time, name, act, want));
      end
   endtask

   task automatic make_req(inout logic [15:0] st, input msrh_lsu_pkg::l2_cmd_t cmd,
                           input int lo, input int span, output msrh_lsu_pkg::l2_req_t req);
      logic [63:0] r;
      int          idx;
      rand_bits(st, 8, r);
      idx = lo + int'(r[7:0]) % span;
      rand_bits(st, 4, r); // byte offset plus one alias bit above the ram
      req.addr = `MSRH_L2_BASE_ADDR + msrh_lsu_pkg::paddr_t'((idx + int'(r[3]) * WORDS) * 8)
                 + msrh_lsu_pkg::paddr_t'(r[2:0]);
      rand_bits(st, `MSRH_L2_DATA_W, r);
      req.data = r;
      rand_bits(st, BE_W, r);
      req.byte_en = r[BE_W-1:0];
      rand_bits(st, TAG_W, r);
      req.tag = r[TAG_W-1:0];
      req.cmd = cmd;
   endtask

   // holds the request until accepted, model updated in accept order
   task automatic send_req(input logic to_l1d, input msrh_lsu_pkg::l2_req_t req);
      logic taken;
      taken = 1'b0;
      while (!taken) begin
         if (to_l1d) begin
            i_l1d_req_valid = 1'b1;
            i_l1d_req       = req;
         end else begin
            i_ic_req_valid = 1'b1;
            i_ic_req       = req;
         end
         #(T_SAMPLE);
         taken = to_l1d ? o_l1d_req_ready : o_ic_req_ready;
         if (taken && req.cmd == msrh_lsu_pkg::L2_CMD_WR) begin
            model_write(req);
         end else if (taken && to_l1d) begin
            exp_l1d.push_back(ref_resp(req, 1'b1));
         end else if (taken) begin
            exp_ic.push_back(ref_resp(req, 1'b0));
         end
         @(negedge i_clk);
      end
      i_l1d_req_valid = to_l1d ? 1'b0 : i_l1d_req_valid;
      i_ic_req_valid  = to_l1d ? i_ic_req_valid : 1'b0;
   endtask

   task automatic watch_resp(input logic is_l1d);
      logic [63:0]            r;
      logic                   rdy;
      logic                   vld;
      msrh_lsu_pkg::l2_resp_t act;
      msrh_lsu_pkg::l2_resp_t want;
      forever begin
         @(negedge i_clk);
         rdy = 1'b1;
         if (stall_en && is_l1d) begin
            rand_bits(st_l1d_stall, 1, r);
            rdy = r[0];
         end else if (stall_en) begin
            rand_bits(st_ic_stall, 1, r);
            rdy = r[0];
         end
         if (is_l1d) begin
            i_l1d_resp_ready = rdy;
         end else begin
            i_ic_resp_ready = rdy;
         end
         #(T_CHECK);
         vld = is_l1d ? o_l1d_resp_valid : o_ic_resp_valid;
         act = is_l1d ? o_l1d_resp : o_ic_resp;
         if (is_l1d && exp_l1d.size() == 0) begin
            check_valid("o_l1d_resp_valid", vld, 1'b0);
         end else if (!is_l1d && exp_ic.size() == 0) begin
            check_valid("o_ic_resp_valid", vld, 1'b0);
         end else if (vld && rdy && is_l1d) begin
            want = exp_l1d.pop_front();
            check_resp("o_l1d_resp", act, want);
         end else if (vld && rdy) begin
            want = exp_ic.pop_front();
            check_resp("o_ic_resp", act, want);
         end
      end
   endtask

   task automatic wait_drain();
      while (exp_l1d.size() != 0 || exp_ic.size() != 0) begin
         @(negedge i_clk);
      end
   endtask

   // l1d mixes reads and writes in the low half, ic reads the high half
   task automatic run_traffic(input logic to_l1d);
      logic [63:0]           r;
      msrh_lsu_pkg::l2_req_t req;
      for (int n = 0; n < N_MIX; n++) begin
         if (to_l1d) begin
            rand_bits(st_main, 1, r);
            make_req(st_main, r[0], 0, WORDS / 2, req);
         end else begin
            make_req(st_ic, msrh_lsu_pkg::L2_CMD_RD, WORDS / 2, WORDS / 2, req);
         end
         send_req(to_l1d, req);
      end
   endtask

   initial begin
      #(T_WD);
      fail_run("timeout: responses stalled before every request completed");
   end

   initial begin
      wait (i_msrh_reset_n === 1'b1);
      fork
         watch_resp(1'b1);
         watch_resp(1'b0);
      join
   end

   initial begin
      msrh_lsu_pkg::l2_req_t req;
      i_msrh_reset_n   = 1'b0;
      i_l1d_req_valid  = 1'b0;
      i_l1d_req        = '0;
      i_l1d_resp_ready = 1'b1;
      i_ic_req_valid   = 1'b0;
      i_ic_req         = '0;
      i_ic_resp_ready  = 1'b1;
      stall_en         = 1'b0;
      st_main          = SEED;
      st_ic            = SEED;
      st_l1d_stall     = SEED;
      st_ic_stall      = SEED;
      repeat (1000) st_ic = lfsr_step(st_ic); // separate streams, same seed
      repeat (2000) st_l1d_stall = lfsr_step(st_l1d_stall);
      repeat (3000) st_ic_stall = lfsr_step(st_ic_stall);

      for (int c = 0; c < 16; c++) begin
         @(negedge i_clk);
         check_valid("o_l1d_resp_valid", o_l1d_resp_valid, 1'b0);
         check_valid("o_ic_resp_valid", o_ic_resp_valid, 1'b0);
         check_valid("o_l1d_req_ready", o_l1d_req_ready, 1'b1);
         check_valid("o_ic_req_ready", o_ic_req_ready, 1'b1);
      end
      i_msrh_reset_n = 1'b1;

      for (int w = 0; w < WORDS; w++) begin
         req.cmd     = msrh_lsu_pkg::L2_CMD_WR;
         req.addr    = `MSRH_L2_BASE_ADDR + msrh_lsu_pkg::paddr_t'(w * BE_W);
         req.tag     = '0;
         req.data    = {req.addr, ~req.addr}; // unique per word
         req.byte_en = '1;
         send_req(1'b1, req);
      end

      // partial writes, then read back the merged words
      for (int n = 0; n < N_BURST; n++) begin
         make_req(st_main, msrh_lsu_pkg::L2_CMD_WR, 0, WORDS, req);
         wr_list.push_back(req.addr);
         send_req(1'b1, req);
      end
      for (int n = 0; n < N_BURST; n++) begin
         make_req(st_main, msrh_lsu_pkg::L2_CMD_RD, 0, WORDS, req);
         req.addr = wr_list[n];
         send_req(1'b1, req);
      end
      wait_drain();

      for (int n = 0; n < N_BURST; n++) begin
         make_req(st_main, msrh_lsu_pkg::L2_CMD_RD, 0, WORDS, req);
         send_req(1'b0, req);
      end
      wait_drain();

      fork
         run_traffic(1'b1);
         run_traffic(1'b0);
      join
      wait_drain();

      stall_en = 1'b1;
      fork
         run_traffic(1'b1);
         run_traffic(1'b0);
      join
      wait_drain();
      stall_en = 1'b0;

      // a duplicate response would still show up within the read latency
      repeat (`MSRH_L2_RD_LAT + 2) @(posedge i_clk);
      $display("test passed");
      $finish;
   end

endmodule

/* source/msrh_l2_arbiter.sv */
module msrh_l2_arbiter (
   // l1d side, high priority
   input  logic                   i_l1d_valid,
   input  msrh_lsu_pkg::l2_req_t  i_l1d,
   output logic                   o_l1d_ready,

   // ic side
   input  logic                   i_ic_valid,
   input  msrh_lsu_pkg::l2_req_t  i_ic,
   output logic                   o_ic_ready,

   // merged request to ram
   output logic                   o_req_valid,
   output msrh_lsu_pkg::l2_req_t  o_req,
   input  logic                   i_req_ready,

   // response from ram
   input  logic                   i_resp_valid,
   input  msrh_lsu_pkg::l2_resp_t i_resp,
   output logic                   o_resp_ready,

   output logic                   o_l1d_resp_valid,
   output msrh_lsu_pkg::l2_resp_t o_l1d_resp,
   input  logic                   i_l1d_resp_ready,

   output logic                   o_ic_resp_valid,
   output msrh_lsu_pkg::l2_resp_t o_ic_resp,
   input  logic                   i_ic_resp_ready
);

   localparam int SRC_BIT = $bits(msrh_lsu_pkg::l2_tag_t) - 1;

   logic w_resp_to_l1d;

   // fixed priority, l1d always wins
   assign o_req_valid = i_l1d_valid | i_ic_valid;
   assign o_req       = i_l1d_valid ? i_l1d : i_ic;
   assign o_l1d_ready = i_req_ready;
   assign o_ic_ready  = !i_l1d_valid & i_req_ready;

   // source bit 1 is l1d
   assign w_resp_to_l1d = i_resp.tag[SRC_BIT];

   assign o_l1d_resp_valid = i_resp_valid & w_resp_to_l1d;
   assign o_ic_resp_valid  = i_resp_valid & !w_resp_to_l1d;
   assign o_l1d_resp       = i_resp;
   assign o_ic_resp        = i_resp;

   // the other side's ready must not leak through
   assign o_resp_ready = w_resp_to_l1d ? i_l1d_resp_ready : i_ic_resp_ready;

endmodule

/* source/msrh_l2_behavior_ram.sv */
`include "msrh_l2_params.svh"

module msrh_l2_behavior_ram (
   input  logic                   i_clk,
   input  logic                   i_msrh_reset_n,

   input  logic                   i_req_valid,
   input  msrh_lsu_pkg::l2_req_t  i_req,
   output logic                   o_req_ready,

   output logic                   o_resp_valid,
   output msrh_lsu_pkg::l2_resp_t o_resp,
   input  logic                   i_resp_ready
);

   localparam int RD_LAT = `MSRH_L2_RD_LAT;
   localparam int BYTES  = `MSRH_L2_DATA_W / 8;
   localparam int OFS_W  = $clog2(BYTES);
   localparam int IDX_W  = $clog2(`MSRH_L2_RAM_WORDS);

   msrh_lsu_pkg::l2_data_t r_mem [`MSRH_L2_RAM_WORDS];

   // stage 0 captures at accept, stage RD_LAT drives the response
   logic [RD_LAT:0]        r_pipe_valid;
   msrh_lsu_pkg::l2_resp_t r_pipe [RD_LAT+1];

   msrh_lsu_pkg::paddr_t   w_offset;
   logic [IDX_W-1:0]       w_idx;
   logic                   w_stall;
   logic                   w_accept;
   logic                   w_rd_accept;
   logic                   w_wr_accept;

   // whole pipe freezes on back-pressure
   assign w_stall     = r_pipe_valid[RD_LAT] & !i_resp_ready;
   assign o_req_ready = !w_stall;
   assign w_accept    = i_req_valid & o_req_ready;
   assign w_rd_accept = w_accept & (i_req.cmd == msrh_lsu_pkg::L2_CMD_RD);
   assign w_wr_accept = w_accept & (i_req.cmd == msrh_lsu_pkg::L2_CMD_WR);

   // word index wraps at ram depth
   assign w_offset = i_req.addr - msrh_lsu_pkg::paddr_t'(`MSRH_L2_BASE_ADDR);
   assign w_idx    = w_offset[OFS_W +: IDX_W];

   always_ff @(posedge i_clk) begin
      if (w_wr_accept) begin
         for (int b = 0; b < BYTES; b++) begin
            if (i_req.byte_en[b]) begin
               r_mem[w_idx][b*8 +: 8] <= i_req.data[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_msrh_reset_n) begin
         r_pipe_valid <= '0;
      end else if (!w_stall) begin
         r_pipe_valid <= {r_pipe_valid[RD_LAT-1:0], w_rd_accept};
      end
   end

   // data sampled at accept, so later writes don't disturb it
   always_ff @(posedge i_clk) begin
      if (!w_stall) begin
         r_pipe[0].tag  <= i_req.tag;
         r_pipe[0].data <= r_mem[w_idx];
         for (int s = 1; s <= RD_LAT; s++) begin
            r_pipe[s] <= r_pipe[s-1];
         end
      end
   end

   assign o_resp_valid = r_pipe_valid[RD_LAT];
   assign o_resp       = r_pipe[RD_LAT];

endmodule

/* source/msrh_l2_params.svh */
`ifndef MSRH_L2_PARAMS_SVH
`define MSRH_L2_PARAMS_SVH

// physical byte address
`define MSRH_PADDR_W 32

// one L2 word
`define MSRH_L2_DATA_W 64

// top bit is the source id, low bits belong to the requester
`define MSRH_L2_TAG_W 4

`define MSRH_L2_RAM_WORDS 256 // power of two
`define MSRH_L2_BASE_ADDR 32'h8000_0000

// edges from read accept to response valid
`define MSRH_L2_RD_LAT 4

`endif

/* source/msrh_l2_req_port.sv */
module msrh_l2_req_port #(
   parameter logic SRC_ID = 1'b0
) (
   input  logic                   i_clk,
   input  logic                   i_msrh_reset_n,

   // from requester
   input  logic                   i_req_valid,
   input  msrh_lsu_pkg::l2_req_t  i_req,
   output logic                   o_req_ready,

   // to arbiter
   output logic                   o_fwd_valid,
   output msrh_lsu_pkg::l2_req_t  o_fwd,
   input  logic                   i_fwd_ready
);

   localparam int SRC_BIT = $bits(msrh_lsu_pkg::l2_tag_t) - 1;

   logic                  r_valid;
   msrh_lsu_pkg::l2_req_t r_req;
   msrh_lsu_pkg::l2_req_t w_stamped;
   logic                  w_accept;

   // refill in the same cycle the held entry drains
   assign o_req_ready = !r_valid | i_fwd_ready;
   assign w_accept    = i_req_valid & o_req_ready;

   always_comb begin
      w_stamped              = i_req;
      w_stamped.tag[SRC_BIT] = SRC_ID; // response routing key
   end

   always_ff @(posedge i_clk) begin
      if (!i_msrh_reset_n) begin
         r_valid <= 1'b0;
      end else if (w_accept) begin
         r_valid <= 1'b1;
      end else if (i_fwd_ready) begin
         r_valid <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (w_accept) begin
         r_req <= w_stamped;
      end
   end

   assign o_fwd_valid = r_valid;
   assign o_fwd       = r_req;

endmodule

/* source/msrh_l2_subsys.sv */
module msrh_l2_subsys (
   input  logic                   i_clk,
   input  logic                   i_msrh_reset_n,

   // l1d requester
   input  logic                   i_l1d_req_valid,
   input  msrh_lsu_pkg::l2_req_t  i_l1d_req,
   output logic                   o_l1d_req_ready,
   output logic                   o_l1d_resp_valid,
   output msrh_lsu_pkg::l2_resp_t o_l1d_resp,
   input  logic                   i_l1d_resp_ready,

   // ic requester
   input  logic                   i_ic_req_valid,
   input  msrh_lsu_pkg::l2_req_t  i_ic_req,
   output logic                   o_ic_req_ready,
   output logic                   o_ic_resp_valid,
   output msrh_lsu_pkg::l2_resp_t o_ic_resp,
   input  logic                   i_ic_resp_ready
);

   logic                   w_l1d_fwd_valid;
   msrh_lsu_pkg::l2_req_t  w_l1d_fwd;
   logic                   w_l1d_fwd_ready;

   logic                   w_ic_fwd_valid;
   msrh_lsu_pkg::l2_req_t  w_ic_fwd;
   logic                   w_ic_fwd_ready;

   logic                   w_l2_req_valid;
   msrh_lsu_pkg::l2_req_t  w_l2_req;
   logic                   w_l2_req_ready;

   logic                   w_l2_resp_valid;
   msrh_lsu_pkg::l2_resp_t w_l2_resp;
   logic                   w_l2_resp_ready;

   msrh_l2_req_port #(
      .SRC_ID (1'b1)
   ) u_l1d_port (
      .i_clk          (i_clk),
      .i_msrh_reset_n (i_msrh_reset_n),
      .i_req_valid    (i_l1d_req_valid),
      .i_req          (i_l1d_req),
      .o_req_ready    (o_l1d_req_ready),
      .o_fwd_valid    (w_l1d_fwd_valid),
      .o_fwd          (w_l1d_fwd),
      .i_fwd_ready    (w_l1d_fwd_ready)
   );

   msrh_l2_req_port #(
      .SRC_ID (1'b0)
   ) u_ic_port (
      .i_clk          (i_clk),
      .i_msrh_reset_n (i_msrh_reset_n),
      .i_req_valid    (i_ic_req_valid),
      .i_req          (i_ic_req),
      .o_req_ready    (o_ic_req_ready),
      .o_fwd_valid    (w_ic_fwd_valid),
      .o_fwd          (w_ic_fwd),
      .i_fwd_ready    (w_ic_fwd_ready)
   );

   msrh_l2_arbiter u_arbiter (
      .i_l1d_valid      (w_l1d_fwd_valid),
      .i_l1d            (w_l1d_fwd),
      .o_l1d_ready      (w_l1d_fwd_ready),
      .i_ic_valid       (w_ic_fwd_valid),
      .i_ic             (w_ic_fwd),
      .o_ic_ready       (w_ic_fwd_ready),
      .o_req_valid      (w_l2_req_valid),
      .o_req            (w_l2_req),
      .i_req_ready      (w_l2_req_ready),
      .i_resp_valid     (w_l2_resp_valid),
      .i_resp           (w_l2_resp),
      .o_resp_ready     (w_l2_resp_ready),
      .o_l1d_resp_valid (o_l1d_resp_valid),
      .o_l1d_resp       (o_l1d_resp),
      .i_l1d_resp_ready (i_l1d_resp_ready),
      .o_ic_resp_valid  (o_ic_resp_valid),
      .o_ic_resp        (o_ic_resp),
      .i_ic_resp_ready  (i_ic_resp_ready)
   );

   msrh_l2_behavior_ram u_ram (
      .i_clk          (i_clk),
      .i_msrh_reset_n (i_msrh_reset_n),
      .i_req_valid    (w_l2_req_valid),
      .i_req          (w_l2_req),
      .o_req_ready    (w_l2_req_ready),
      .o_resp_valid   (w_l2_resp_valid),
      .o_resp         (w_l2_resp),
      .i_resp_ready   (w_l2_resp_ready)
   );

endmodule

/* source/msrh_lsu_pkg.sv */
`include "msrh_l2_params.svh"

package msrh_lsu_pkg;

   typedef logic [`MSRH_PADDR_W-1:0]     paddr_t;
   typedef logic [`MSRH_L2_DATA_W-1:0]   l2_data_t;
   typedef logic [`MSRH_L2_DATA_W/8-1:0] l2_be_t;
   typedef logic [`MSRH_L2_TAG_W-1:0]    l2_tag_t;

   // 0 read, 1 write
   typedef logic l2_cmd_t;

   localparam l2_cmd_t L2_CMD_RD = 1'b0;
   localparam l2_cmd_t L2_CMD_WR = 1'b1;

   typedef struct packed {
      l2_cmd_t  cmd;
      paddr_t   addr;
      l2_tag_t  tag;
      l2_data_t data;
      l2_be_t   byte_en;
   } l2_req_t;

   // reads only, writes get no response
   typedef struct packed {
      l2_tag_t  tag;
      l2_data_t data;
   } l2_resp_t;

endpackage
